//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_vcs_cart
FILELIST  ?= build.f
PASS_MSG  := Regression passed
SIM       := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- build.f
+incdir+logic
+incdir+dv
logic/vcs_pkg.sv
logic/cpu_bus_if.sv
logic/addr_decode.sv
logic/load_ctrl.sv
logic/bank_switch.sv
logic/cart_memory.sv
logic/vcs_cart_top.sv
dv/tb_vcs_cart.sv

//--- dv/tb_vcs_model.svh
`ifndef TB_VCS_MODEL_SVH
`define TB_VCS_MODEL_SVH

// ================================================
// Reference model, scheme and region rules
// ================================================
function automatic bank_scheme_e scheme_model(input rom_size_t size, input logic [1:0] sw);
  case (size)
    3'b001:  return !sw[1] ? SCH_E0 : (sw[0] ? SCH_F8 : SCH_FE);  // sw3 low picks E0
    3'b011:  return SCH_F6;
    3'b111:  return SCH_F4;
    default: return SCH_4K;
  endcase
endfunction

function automatic bus_region_e region_model(input logic [12:0] a);
  if (a[12]) begin
    // Superchip window only when control bit 2 is set
    if (m_ctrl[`VCS_CTRL_CART_RAM] && a[11:8] == 4'h0) return REG_CART_RAM;
    return REG_ROM;
  end
  if (!a[7]) return REG_TIA;
  return a[9] ? REG_PIA : REG_RIOT_RAM;
endfunction

function automatic logic [14:0] rom_addr_model(input logic [12:0] a);
  if (m_scheme == SCH_E0) begin
    if (a[11:10] == 2'd3) return {5'b00111, a[9:0]};  // Top segment pinned to bank 7
    return {2'b00, m_seg[a[11:10]], a[9:0]};
  end
  return {m_bank, a[11:0]};
endfunction

function automatic logic [7:0] byte_model(input logic [12:0] a);
  case (region_model(a))
    REG_ROM:      return rom_img[rom_addr_model(a)];
    REG_RIOT_RAM: return riot_ram[a[6:0]];
    REG_CART_RAM: return cart_ram[a[6:0]];
    default:      return 8'h00;  // TIA and PIA
  endcase
endfunction

function automatic bit in_range(input logic [12:0] a, input logic [12:0] base, input int n);
  return (a >= base) && (a < 13'(base + 13'(n)));
endfunction

// Bank state moves after the access has used the old bank
task automatic model_access(input logic [12:0] a, input logic we, input logic [7:0] wd);
  bus_region_e r;
  r = region_model(a);
  if (we && r == REG_RIOT_RAM) riot_ram[a[6:0]] = wd;
  if (we && r == REG_CART_RAM) cart_ram[a[6:0]] = wd;
  if (!m_ctrl[`VCS_CTRL_SOFT_RST]) begin
    case (m_scheme)
      SCH_F8: if (in_range(a, `VCS_HS_F8, 2)) m_bank = 3'(a - `VCS_HS_F8);
      SCH_F6: if (in_range(a, `VCS_HS_F6, 4)) m_bank = 3'(a - `VCS_HS_F6);
      SCH_F4: if (in_range(a, `VCS_HS_F4, 8)) m_bank = 3'(a - `VCS_HS_F4);
      SCH_FE: begin
        if (a == `VCS_HS_FE_0) m_bank = 3'd0;
        if (a == `VCS_HS_FE_1) m_bank = 3'd1;
      end
      SCH_E0: if (in_range(a, `VCS_HS_E0, 24)) m_seg[a[4:3]] = a[2:0];
      default: ;
    endcase
  end
endtask

task automatic model_load(input logic [31:0] addr, input logic [7:0] d);
  if (addr[31:24] == `VCS_LOAD_CTRL_PAGE) begin
    m_ctrl = d;
    if (d[`VCS_CTRL_SOFT_RST]) begin
      m_bank = 3'd0;
      m_seg  = '{default: '0};
    end
  end else begin
    rom_img[addr[14:0]] = d;
    if (addr[13:0] == 14'h0) m_size = 3'b000;  // Image restarts at offset 0
    m_size = m_size | addr[14:12];
  end
endtask

// ================================================
// Compare tasks
// ================================================
task automatic check_data(input string name, input logic [7:0] expected, input logic [7:0] actual);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("MISMATCH %s expected %02h actual %02h", name, expected, actual);
  end
endtask

task automatic check_region(input string name, input bus_region_e expected,
                            input bus_region_e actual);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("MISMATCH %s expected %s actual %s", name, expected.name(), actual.name());
  end
endtask

task automatic check_scheme(input string name, input bank_scheme_e expected,
                            input bank_scheme_e actual);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("MISMATCH %s expected %s actual %s", name, expected.name(), actual.name());
  end
endtask

`endif

//--- dv/tb_vcs_cart.sv
`timescale 1ns/10ps
`include "vcs_config.svh"

module tb_vcs_cart;
  import vcs_pkg::*;

  // Rough cycle budget per test where loads dominate
  localparam int LEN_T1      = 9000;
  localparam int LEN_T2      = 17500;
  localparam int LEN_T3      = 50500;
  localparam int LEN_T4      = 9000;
  localparam int LEN_T5      = 1500;
  localparam int LEN_T6      = 800;
  localparam int WATCHDOG_NS = 4 * 10 * (LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5 + LEN_T6);

  logic                   clk_sys;
  logic                   pwr_up_reset_n;
  logic                   bus_valid_i;
  logic [`VCS_ADDR_W-1:0] bus_addr_i;
  logic                   bus_we_i;
  logic [`VCS_DATA_W-1:0] bus_wdata_i;
  logic [1:0]             sw_i;
  logic                   load_valid_i;
  logic [31:0]            load_addr_i;
  logic [7:0]             load_data_i;
  logic [7:0]             rdata_o;
  logic                   rdata_valid_o;
  bus_region_e            region_o;
  bank_scheme_e           scheme_o;
  logic                   load_ready_o;

  // Model state
  logic [7:0]   rom_img [32768];
  logic [7:0]   riot_ram [128];
  logic [7:0]   cart_ram [128];
  logic [2:0]   m_bank = 3'd0;
  logic [2:0]   m_seg [4] = '{default: '0};  // E0 segment banks
  rom_size_t    m_size = 3'b000;
  logic [7:0]   m_ctrl = 8'h00;
  bank_scheme_e m_scheme = SCH_4K;

  integer      seed = 62047;
  int          cyc = 0;
  int          checks = 0;
  int          errors = 0;
  int          err_start = 0;
  string       test_name = "reset";
  logic [7:0]  exp_q [$];   // Pending reads
  int          stamp_q [$];
  string       name_q [$];

  `include "tb_vcs_model.svh"

  vcs_cart_top vcs_cart_top_inst (.*);

  initial begin
    clk_sys = 1'b0;
    forever #5 clk_sys = ~clk_sys;
  end

  always @(posedge clk_sys) cyc <= cyc + 1;

  // ================================================
  // Read compare one cycle after issue
  // ================================================
  always @(negedge clk_sys) begin
    if (stamp_q.size() > 0 && stamp_q[0] < cyc) begin
      if (!rdata_valid_o) begin
        errors++;
        $display("%s read got no rdata_valid_o one cycle later", name_q[0]);
      end else begin
        check_data(name_q[0], exp_q[0], rdata_o);
      end
      void'(exp_q.pop_front());
      void'(stamp_q.pop_front());
      void'(name_q.pop_front());
    end else if (rdata_valid_o === 1'b1) begin
      errors++;
      $display("%s rdata_valid_o high with no read outstanding", test_name);
    end
  end

  // Loader back-pressure during reset and CPU accesses
  always @(negedge clk_sys) begin
    #2;
    if (load_ready_o !== 1'b0 && (pwr_up_reset_n || bus_valid_i)) begin
      errors++;
      $display("%s load_ready_o high during reset or a CPU access", test_name);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests finished");
    $display("Regression failed");
    $finish;
  end

  // ================================================
  // Stimulus tasks
  // ================================================
  task automatic cpu_access(input logic [12:0] a, input logic we, input logic [7:0] wd);
    bus_region_e exp_region;
    @(negedge clk_sys);
    bus_valid_i = 1'b1;
    bus_addr_i  = a;
    bus_we_i    = we;
    bus_wdata_i = wd;
    exp_region  = region_model(a);
    if (!we) begin
      exp_q.push_back(byte_model(a));
      stamp_q.push_back(cyc);
      name_q.push_back(test_name);
    end
    model_access(a, we, wd);
    #1 check_region(test_name, exp_region, region_o);  // Combinational and settled by now
  endtask

  task automatic bus_idle();
    @(negedge clk_sys);
    bus_valid_i = 1'b0;
    bus_we_i    = 1'b0;
  endtask

  task automatic read_burst(input logic [12:0] base, input int span, input int n);
    for (int i = 0; i < n; i++) begin
      cpu_access(13'(base + ({$random(seed)} % span)), 1'b0, 8'h00);
    end
  endtask

  // Holds valid until ready as CPU traffic may stall it
  task automatic load_byte(input logic [31:0] addr, input logic [7:0] d);
    bit done;
    done = 1'b0;
    @(negedge clk_sys);
    load_valid_i = 1'b1;
    load_addr_i  = addr;
    load_data_i  = d;
    while (!done) begin
      #1;
      if (load_ready_o) done = 1'b1;
      else @(negedge clk_sys);
    end
    model_load(addr, d);
  endtask

  task automatic load_idle();
    @(negedge clk_sys);
    load_valid_i = 1'b0;
  endtask

  task automatic settle_scheme();
    repeat (2) @(negedge clk_sys);
    m_scheme = scheme_model(m_size, sw_i);
    check_scheme(test_name, m_scheme, scheme_o);
  endtask

  task automatic load_image(input int n);
    for (int i = 0; i < n; i++) load_byte({17'h0, 15'(i)}, 8'($random(seed)));
    load_idle();
    settle_scheme();
  endtask

  task automatic set_sw(input logic [1:0] v);
    @(negedge clk_sys);
    sw_i = v;
    settle_scheme();
  endtask

  task automatic write_ctrl(input logic [7:0] d);
    load_byte({`VCS_LOAD_CTRL_PAGE, 24'h0}, d);
    load_idle();
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_start = errors;
  endtask

  task automatic end_test();
    bus_idle();
    while (exp_q.size() > 0) @(negedge clk_sys);
    $display("Test %s finished with %0d errors", test_name, errors - err_start);
  endtask

  // ================================================
  // Test sequence
  // ================================================
  initial begin
    pwr_up_reset_n = 1'b1;
    bus_valid_i    = 1'b0;
    bus_addr_i     = '0;
    bus_we_i       = 1'b0;
    bus_wdata_i    = '0;
    sw_i           = 2'b11;  // sw3 and sw2 high select F8 for 8 KB
    load_valid_i   = 1'b0;
    load_addr_i    = '0;
    load_data_i    = '0;
    repeat (16) @(negedge clk_sys);
    pwr_up_reset_n = 1'b0;

    begin_test("rom_4k");
    load_image(4096);
    for (int a = 'h1000; a < 'h2000; a++) cpu_access(13'(a), 1'b0, 8'h00);
    end_test();

    begin_test("f8_fe");
    load_image(8192);
    read_burst(13'h1000, 4096, 16);
    cpu_access(13'h1FF9, 1'b0, 8'h00);         // Own read from old bank
    read_burst(13'h1000, 4096, 32);
    bus_idle();
    set_sw(2'b10);
    cpu_access(13'h11FE, 1'b0, 8'h00);
    read_burst(13'h1000, 4096, 32);
    cpu_access(13'h01FE, 1'b1, 8'($random(seed)));  // Write hits the hotspot too
    read_burst(13'h1000, 4096, 32);
    end_test();

    begin_test("f6_f4");
    load_image(16384);
    repeat (150) begin
      read_burst(13'h1FF4, 12, 1);
      read_burst(13'h1000, 4096, 1);
    end
    bus_idle();
    load_image(32768);
    repeat (150) begin
      read_burst(13'h1FF2, 14, 1);
      read_burst(13'h1000, 4096, 1);
    end
    end_test();

    begin_test("e0");
    set_sw(2'b00);
    load_image(8192);
    cpu_access(13'h1FE1, 1'b0, 8'h00);
    cpu_access(13'h1FEC, 1'b0, 8'h00);
    cpu_access(13'h1FF6, 1'b0, 8'h00);
    read_burst(13'h1000, 4096, 64);
    repeat (100) begin
      read_burst(13'h1FE0, 24, 1);
      read_burst(13'h1000, 4096, 2);
    end
    end_test();

    begin_test("ram");
    for (int i = 0; i < 128; i++) cpu_access(13'h0080 + 13'(i), 1'b1, 8'($random(seed)));
    for (int i = 0; i < 128; i++) cpu_access(13'h0080 + 13'(i), 1'b0, 8'h00);
    read_burst(13'h0000, 128, 32);            // TIA
    read_burst(13'h0280, 128, 32);            // PIA
    read_burst(13'h1000, 256, 32);            // ROM while cart RAM is off
    bus_idle();
    write_ctrl(8'h04);
    for (int i = 0; i < 128; i++) cpu_access(13'h1000 + 13'(i), 1'b1, 8'($random(seed)));
    for (int i = 0; i < 128; i++) cpu_access(13'h1080 + 13'(i), 1'b0, 8'h00);
    end_test();

    begin_test("soft_reset");
    set_sw(2'b11);
    cpu_access(13'h1FF9, 1'b0, 8'h00);
    read_burst(13'h1100, 3840, 16);
    bus_idle();
    write_ctrl(8'h01);                        // Banks held at 0
    cpu_access(13'h1FF9, 1'b0, 8'h00);
    read_burst(13'h1100, 3840, 16);
    bus_idle();
    write_ctrl(8'h00);
    cpu_access(13'h1FF9, 1'b0, 8'h00);
    bus_idle();
    fork
      for (int i = 0; i < 64; i++) load_byte(32'h0000_1100 + 32'(i), 8'($random(seed)));
      for (int i = 0; i < 40; i++) begin
        cpu_access(13'h1100 + 13'(i % 64), 1'b0, 8'h00);
        cpu_access(13'h1101 + 13'(i % 63), 1'b0, 8'h00);
        bus_idle();
      end
    join
    load_idle();
    for (int i = 0; i < 64; i++) cpu_access(13'h1100 + 13'(i), 1'b0, 8'h00);
    end_test();

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- logic/addr_decode.sv
`timescale 1ns/10ps
`include "vcs_config.svh"

module addr_decode (
  cpu_bus_if.decode bus,
  input  logic      cart_ram_en_i
);
  import vcs_pkg::*;

  logic [`VCS_ADDR_W-1:0] a;
  logic                   low_page;  // Bits 11:8 all zero

  assign a        = bus.addr;
  assign low_page = (a[11:8] == 4'h0);

  // ================================================
  // Region decode, TIA first as in the console
  // ================================================
  always_comb begin
    bus.region = REG_NONE;
    if (!a[12]) begin
      // Lower 4 KB holds the chips
      if (!a[7]) begin
        bus.region = REG_TIA;          // A7 low selects TIA
      end else if (a[9]) begin
        bus.region = REG_PIA;          // A9 high, 6532 I/O
      end else begin
        bus.region = REG_RIOT_RAM;     // A9 low, 6532 RAM
      end
    end else if (cart_ram_en_i && low_page) begin
      // Superchip overlays first 256 bytes of the cart window
      bus.region = REG_CART_RAM;
    end else begin
      bus.region = REG_ROM;
    end
  end

endmodule

//--- logic/bank_switch.sv
`timescale 1ns/10ps
`include "vcs_config.svh"

module bank_switch (
  input  logic                   clk_sys,
  input  logic                   pwr_up_reset_n,
  cpu_bus_if.bank                bus,
  input  vcs_pkg::rom_size_t     rom_size_i,
  input  logic [1:0]             sw_i,         // [0] sw2, [1] sw3
  input  logic                   soft_rst_i,
  output logic [`VCS_ROM_AW-1:0] rom_addr_o,
  output vcs_pkg::bank_scheme_e  scheme_o
);
  import vcs_pkg::*;

  bank_scheme_e           scheme_d;
  bank_scheme_e           scheme_q;
  logic [2:0]             bank_q;    // 4 KB bank for F8, FE, F6, F4
  logic [2:0]             bank0_q;   // E0 segment banks
  logic [2:0]             bank1_q;
  logic [2:0]             bank2_q;
  logic [`VCS_ADDR_W-1:0] a;
  logic [`VCS_ADDR_W-1:0] off_f8;    // Distance from each hotspot base
  logic [`VCS_ADDR_W-1:0] off_f6;
  logic [`VCS_ADDR_W-1:0] off_f4;
  logic [`VCS_ADDR_W-1:0] off_e0;
  logic [`VCS_ROM_AW-1:0] mapped;

  assign a = bus.addr;

  // ================================================
  // Scheme selection
  // ================================================
  always_comb begin
    scheme_d = SCH_4K;
    if (rom_size_i == 3'b001) begin
      if (!sw_i[1])     scheme_d = SCH_E0;  // sw3 low
      else if (sw_i[0]) scheme_d = SCH_F8;  // sw2 high
      else              scheme_d = SCH_FE;
    end else if (rom_size_i == 3'b011) begin
      scheme_d = SCH_F6;
    end else if (rom_size_i == 3'b111) begin
      scheme_d = SCH_F4;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (pwr_up_reset_n) scheme_q <= SCH_4K;
    else                scheme_q <= scheme_d;
  end

  assign scheme_o = scheme_q;

  // ================================================
  // Hotspot tracking
  // ================================================
  // Addresses below a base wrap high and miss the range check
  assign off_f8 = a - `VCS_HS_F8;
  assign off_f6 = a - `VCS_HS_F6;
  assign off_f4 = a - `VCS_HS_F4;
  assign off_e0 = a - `VCS_HS_E0;

  always_ff @(posedge clk_sys) begin
    if (pwr_up_reset_n || soft_rst_i) begin
      bank_q  <= '0;
      bank0_q <= '0;
      bank1_q <= '0;
      bank2_q <= '0;
    end else if (bus.valid) begin
      case (scheme_q)
        SCH_F8: if (off_f8 < 13'd2) bank_q <= off_f8[2:0];
        SCH_F6: if (off_f6 < 13'd4) bank_q <= off_f6[2:0];
        SCH_F4: if (off_f4 < 13'd8) bank_q <= off_f4[2:0];
        SCH_FE: begin
          if (a == `VCS_HS_FE_0)      bank_q <= 3'd0;
          else if (a == `VCS_HS_FE_1) bank_q <= 3'd1;
        end
        SCH_E0: begin
          if (off_e0 < 13'd24) begin
            case (off_e0[4:3])           // Group of eight picks the segment
              2'd0:    bank0_q <= off_e0[2:0];
              2'd1:    bank1_q <= off_e0[2:0];
              default: bank2_q <= off_e0[2:0];
            endcase
          end
        end
        default: ;                       // 4 KB has no hotspots
      endcase
    end
  end

  // ================================================
  // ROM address mapping
  // ================================================
  always_comb begin
    mapped = {bank_q, a[11:0]};
    if (scheme_q == SCH_E0) begin
      case (a[11:10])
        2'd0:    mapped = {bank0_q, a[9:0]};
        2'd1:    mapped = {bank1_q, a[9:0]};
        2'd2:    mapped = {bank2_q, a[9:0]};
        default: mapped = {3'b111, a[9:0]};  // Last 1 KB fixed
      endcase
    end
  end

  // Park ROM address outside the cart window
  assign rom_addr_o = (bus.region == REG_ROM) ? mapped : '0;

endmodule

//--- logic/cart_memory.sv
`timescale 1ns/10ps
`include "vcs_config.svh"

module cart_memory (
  input  logic                   clk_sys,
  input  logic                   pwr_up_reset_n,
  cpu_bus_if.mem                 bus,
  input  logic [`VCS_ROM_AW-1:0] rom_addr_i,
  input  logic                   rom_wr_i,
  input  logic [`VCS_ROM_AW-1:0] rom_waddr_i,
  input  logic [`VCS_DATA_W-1:0] rom_wdata_i,
  output logic [`VCS_DATA_W-1:0] rdata_o,
  output logic                   rdata_valid_o
);
  import vcs_pkg::*;

  localparam int ROM_DEPTH = 1 << `VCS_ROM_AW;
  localparam int RAM_DEPTH = 1 << `VCS_RAM_AW;

  // ================================================
  // Storage
  // ================================================
  logic [`VCS_DATA_W-1:0] rom_mem [ROM_DEPTH];
  logic [`VCS_DATA_W-1:0] ram_mem [2][RAM_DEPTH];  // [0] RIOT, [1] cart

  logic                   ram_hit;   // Access lands in either RAM
  logic                   ram_sel;   // High for cart RAM
  logic                   ram_wr;
  logic                   rd_en;
  logic [`VCS_RAM_AW-1:0] ram_addr;
  logic [`VCS_DATA_W-1:0] rd_mux;

  assign ram_sel  = (bus.region == REG_CART_RAM);
  assign ram_hit  = ram_sel || (bus.region == REG_RIOT_RAM);
  assign ram_addr = bus.addr[`VCS_RAM_AW-1:0];
  assign ram_wr   = bus.valid && bus.we && ram_hit;
  assign rd_en    = bus.valid && !bus.we;

  // Loader port and CPU RAM writes
  always_ff @(posedge clk_sys) begin
    if (rom_wr_i) rom_mem[rom_waddr_i] <= rom_wdata_i;
    if (ram_wr)   ram_mem[ram_sel][ram_addr] <= bus.wdata;
  end

  // ================================================
  // Read multiplexer
  // ================================================
  always_comb begin
    case (bus.region)
      REG_ROM:      rd_mux = rom_mem[rom_addr_i];
      REG_RIOT_RAM,
      REG_CART_RAM: rd_mux = ram_mem[ram_sel][ram_addr];
      default:      rd_mux = '0;  // TIA, PIA and unmapped read 0
    endcase
  end

  always_ff @(posedge clk_sys) begin
    if (rd_en) rdata_o <= rd_mux;  // Byte lands one cycle after the read
  end

  always_ff @(posedge clk_sys) begin
    if (pwr_up_reset_n) rdata_valid_o <= 1'b0;
    else                rdata_valid_o <= rd_en;
  end

endmodule

//--- logic/cpu_bus_if.sv
`timescale 1ns/10ps
`include "vcs_config.svh"

// One CPU access, strobed by valid for a single cycle
interface cpu_bus_if;
  import vcs_pkg::*;

  logic                   valid;   // Access strobe
  logic [`VCS_ADDR_W-1:0] addr;    // 13-bit CPU address
  logic [`VCS_DATA_W-1:0] wdata;   // Write byte
  logic                   we;      // High for writes
  bus_region_e            region;  // Decoded target

  // Address decoder fills in the region
  modport decode (
    input  addr,
    output region
  );

  // Bank logic watches for hotspots
  modport bank (
    input  valid,
    input  addr,
    input  region
  );

  // Memories see the whole access
  modport mem (
    input  valid,
    input  addr,
    input  wdata,
    input  we,
    input  region
  );

endinterface

//--- logic/load_ctrl.sv
`timescale 1ns/10ps
`include "vcs_config.svh"

module load_ctrl (
  input  logic                    clk_sys,
  input  logic                    pwr_up_reset_n,
  input  logic                    load_valid_i,
  input  logic [`VCS_LOAD_AW-1:0] load_addr_i,
  input  logic [`VCS_DATA_W-1:0]  load_data_i,
  input  logic                    bus_valid_i,
  output logic                    load_ready_o,
  output logic                    rom_wr_o,
  output logic [`VCS_ROM_AW-1:0]  rom_waddr_o,
  output logic [`VCS_DATA_W-1:0]  rom_wdata_o,
  output vcs_pkg::rom_size_t      rom_size_o,
  output logic                    soft_rst_o,
  output logic                    cart_ram_en_o
);
  import vcs_pkg::*;

  logic                   ready_q;    // Loader allowed once out of reset
  logic                   load_fire;  // Transfer this edge
  logic                   ctrl_wr;
  logic [7:0]             load_page;  // Top address byte
  logic [`VCS_DATA_W-1:0] ctrl_q;     // CPU control byte
  rom_size_t              size_q;

  // ================================================
  // Loader handshake
  // ================================================
  assign load_page    = load_addr_i[`VCS_LOAD_AW-1 -: 8];
  assign load_ready_o = ready_q && !bus_valid_i;  // Back-pressure on CPU access
  assign load_fire    = load_valid_i && load_ready_o;
  assign rom_wr_o     = load_fire && (load_page == `VCS_LOAD_ROM_PAGE);
  assign ctrl_wr      = load_fire && (load_page == `VCS_LOAD_CTRL_PAGE);
  assign rom_waddr_o  = load_addr_i[`VCS_ROM_AW-1:0];
  assign rom_wdata_o  = load_data_i;

  always_ff @(posedge clk_sys) begin
    if (pwr_up_reset_n) begin
      ready_q <= 1'b0;
      ctrl_q  <= '0;
    end else begin
      ready_q <= 1'b1;
      if (ctrl_wr) ctrl_q <= load_data_i;  // Control page write
    end
  end

  // ================================================
  // ROM size from loader addresses
  // ================================================
  always_ff @(posedge clk_sys) begin
    if (pwr_up_reset_n) begin
      size_q <= '0;
    end else if (rom_wr_o) begin
      // New image starts at offset 0, forget the old size
      if (load_addr_i[`VCS_ROM_AW-2:0] == '0) size_q <= '0;
      // Later assignments win over the clear
      for (int i = 0; i < 3; i++) begin
        if (load_addr_i[12 + i]) size_q[i] <= 1'b1;  // A12..A14 seen
      end
    end
  end

  assign rom_size_o    = size_q;
  assign soft_rst_o    = ctrl_q[`VCS_CTRL_SOFT_RST];
  assign cart_ram_en_o = ctrl_q[`VCS_CTRL_CART_RAM];

endmodule

//--- logic/vcs_cart_top.sv
`timescale 1ns/10ps
`include "vcs_config.svh"

module vcs_cart_top (
  input  logic                    clk_sys,
  input  logic                    pwr_up_reset_n,
  // CPU bus
  input  logic                    bus_valid_i,
  input  logic [`VCS_ADDR_W-1:0]  bus_addr_i,
  input  logic                    bus_we_i,
  input  logic [`VCS_DATA_W-1:0]  bus_wdata_i,
  input  logic [1:0]              sw_i,
  // ROM loader
  input  logic                    load_valid_i,
  input  logic [`VCS_LOAD_AW-1:0] load_addr_i,
  input  logic [`VCS_DATA_W-1:0]  load_data_i,
  // Results
  output logic [`VCS_DATA_W-1:0]  rdata_o,
  output logic                    rdata_valid_o,
  output vcs_pkg::bus_region_e    region_o,
  output vcs_pkg::bank_scheme_e   scheme_o,
  output logic                    load_ready_o
);
  import vcs_pkg::*;

  // ================================================
  // Internal wiring
  // ================================================
  cpu_bus_if bus_if ();

  logic                   rom_wr;
  logic [`VCS_ROM_AW-1:0] rom_waddr;
  logic [`VCS_DATA_W-1:0] rom_wdata;
  logic [`VCS_ROM_AW-1:0] rom_addr;   // Banked read address
  rom_size_t              rom_size;
  logic                   soft_rst;   // Control bit 0
  logic                   cart_ram_en; // Control bit 2

  assign bus_if.valid = bus_valid_i;
  assign bus_if.addr  = bus_addr_i;
  assign bus_if.wdata = bus_wdata_i;
  assign bus_if.we    = bus_we_i;
  assign region_o     = bus_if.region;

  // ================================================
  // Blocks
  // ================================================
  addr_decode addr_decode_inst (
    .bus           (bus_if.decode),
    .cart_ram_en_i (cart_ram_en)
  );

  load_ctrl load_ctrl_inst (
    .clk_sys        (clk_sys),
    .pwr_up_reset_n (pwr_up_reset_n),
    .load_valid_i   (load_valid_i),
    .load_addr_i    (load_addr_i),
    .load_data_i    (load_data_i),
    .bus_valid_i    (bus_valid_i),
    .load_ready_o   (load_ready_o),
    .rom_wr_o       (rom_wr),
    .rom_waddr_o    (rom_waddr),
    .rom_wdata_o    (rom_wdata),
    .rom_size_o     (rom_size),
    .soft_rst_o     (soft_rst),
    .cart_ram_en_o  (cart_ram_en)
  );

  bank_switch bank_switch_inst (
    .clk_sys        (clk_sys),
    .pwr_up_reset_n (pwr_up_reset_n),
    .bus            (bus_if.bank),
    .rom_size_i     (rom_size),
    .sw_i           (sw_i),
    .soft_rst_i     (soft_rst),
    .rom_addr_o     (rom_addr),
    .scheme_o       (scheme_o)
  );

  cart_memory cart_memory_inst (
    .clk_sys        (clk_sys),
    .pwr_up_reset_n (pwr_up_reset_n),
    .bus            (bus_if.mem),
    .rom_addr_i     (rom_addr),
    .rom_wr_i       (rom_wr),
    .rom_waddr_i    (rom_waddr),
    .rom_wdata_i    (rom_wdata),
    .rdata_o        (rdata_o),
    .rdata_valid_o  (rdata_valid_o)
  );

endmodule

//--- logic/vcs_config.svh
`ifndef VCS_CONFIG_SVH
`define VCS_CONFIG_SVH

// ================================================
// Word sizes
// ================================================
`define VCS_ADDR_W          13      // 6507 address bus
`define VCS_DATA_W          8
`define VCS_ROM_AW          15      // 32 KB cartridge image
`define VCS_RAM_AW          7       // 128 bytes each for RIOT and cart RAM
`define VCS_LOAD_AW         32

// Control register bits
`define VCS_CTRL_SOFT_RST   0
`define VCS_CTRL_CART_RAM   2

// Loader pages, taken from the top address byte
`define VCS_LOAD_ROM_PAGE   8'h00
`define VCS_LOAD_CTRL_PAGE  8'hFF

// ================================================
// Hotspot bases
// ================================================
`define VCS_HS_E0           13'h1FE0
`define VCS_HS_FE_0         13'h01FE
`define VCS_HS_FE_1         13'h11FE
`define VCS_HS_F8           13'h1FF8
`define VCS_HS_F6           13'h1FF6
`define VCS_HS_F4           13'h1FF4

`endif

//--- logic/vcs_pkg.sv
package vcs_pkg;

  // ================================================
  // Bus regions seen by the CPU
  // ================================================
  typedef enum logic [2:0] {
    REG_NONE     = 3'd0,  // Nothing selected
    REG_TIA      = 3'd1,  // Video and audio chip, reads 0 here
    REG_RIOT_RAM = 3'd2,  // 128 bytes in the 6532
    REG_PIA      = 3'd3,  // 6532 ports and timer, reads 0 here
    REG_CART_RAM = 3'd4,  // Superchip RAM
    REG_ROM      = 3'd5   // Cartridge ROM window
  } bus_region_e;

  // ================================================
  // Bank switching schemes
  // ================================================
  typedef enum logic [2:0] {
    SCH_4K = 3'd0,  // Plain 4 KB, no switching
    SCH_F8 = 3'd1,  // 2 x 4 KB
    SCH_FE = 3'd2,  // 2 x 4 KB, stack hotspots
    SCH_E0 = 3'd3,  // 8 x 1 KB in four segments
    SCH_F6 = 3'd4,  // 4 x 4 KB
    SCH_F4 = 3'd5   // 8 x 4 KB
  } bank_scheme_e;

  // Image size flags
  // [0] 8 KB seen, [1] 16 KB seen, [2] 32 KB seen
  typedef logic [2:0] rom_size_t;

endpackage
